// File: hw/sv39_pkg.sv
package sv39_pkg;

    // ------------------------------------------------------------
    // address geometry
    // ------------------------------------------------------------

    // virtual address width, three-level sv39 scheme
    localparam int unsigned VLEN = 39;
    // physical address width
    localparam int unsigned PLEN = 56;
    // physical page number width
    localparam int unsigned PPNW = 44;
    // virtual page number, three 9-bit levels
    localparam int unsigned VPNW = 27;
    // offset inside a 4 KiB page
    localparam int unsigned PAGE_OFS = 12;

    // page size held with every tlb entry
    // 2M pages ignore vpn level 0, 1G pages ignore levels 1 and 0
    typedef enum logic [1:0] {
        PAGE_4K = 2'd0,
        PAGE_2M = 2'd1,
        PAGE_1G = 2'd2
    } page_size_e;

    // ------------------------------------------------------------
    // pte flag vector
    // ------------------------------------------------------------

    // width of the flag field at the bottom of a pte
    localparam int unsigned NFLAGS = 8;

    // bit positions inside the flag vector, same order as the pte
    localparam int unsigned FLAG_V = 0;
    localparam int unsigned FLAG_R = 1;
    localparam int unsigned FLAG_W = 2;
    localparam int unsigned FLAG_X = 3;
    // user page
    localparam int unsigned FLAG_U = 4;
    // global mapping, kept for completeness of the pte layout
    localparam int unsigned FLAG_G = 5;
    // accessed and dirty are never set by hardware here
    localparam int unsigned FLAG_A = 6;
    localparam int unsigned FLAG_D = 7;

endpackage

// File: hw/mmu_pkg.sv
package mmu_pkg;

    // ------------------------------------------------------------
    // privilege levels
    // ------------------------------------------------------------

    // encoding follows the privileged spec
    // level 2 is reserved and never used
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_lvl_e;

    // ------------------------------------------------------------
    // exception causes
    // ------------------------------------------------------------

    // only the page fault causes of the load/store path remain
    // values match the mcause exception codes
    typedef enum logic [3:0] {
        EXC_NONE          = 4'd0,
        EXC_LD_PAGE_FAULT = 4'd13,
        EXC_ST_PAGE_FAULT = 4'd15
    } exc_cause_e;

endpackage

// File: hw/dtlb.sv
`timescale 1ns/1ps

module dtlb import sv39_pkg::*; #(
    parameter int unsigned DTLB_ENTRIES = 4
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    // clears every entry and the refill pointer
    input  logic              flush_i,
    // refill port
    input  logic              upd_valid_i,
    input  logic [VPNW-1:0]   upd_vpn_i,
    input  page_size_e        upd_size_i,
    input  logic [PPNW-1:0]   upd_ppn_i,
    input  logic [NFLAGS-1:0] upd_flags_i,
    // lookup port, answered in the same cycle
    input  logic [VLEN-1:0]   lu_vaddr_i,
    output logic              lu_hit_o,
    output logic [PPNW-1:0]   lu_ppn_o,
    output logic [NFLAGS-1:0] lu_flags_o,
    output page_size_e        lu_size_o
);

    // width of one vpn level
    localparam int unsigned LVLW = VPNW / 3;
    // pointer needs at least one bit even for a single entry
    localparam int unsigned PTRW = (DTLB_ENTRIES > 1) ? $clog2(DTLB_ENTRIES) : 1;

    // entry storage
    logic [VPNW-1:0]   tag_q   [DTLB_ENTRIES];
    page_size_e        size_q  [DTLB_ENTRIES];
    logic [PPNW-1:0]   ppn_q   [DTLB_ENTRIES];
    logic [NFLAGS-1:0] flags_q [DTLB_ENTRIES];
    logic [DTLB_ENTRIES-1:0] valid_q;

    // round-robin refill pointer
    logic [PTRW-1:0] ptr_q;

    logic [VPNW-1:0]         lu_vpn;
    logic [DTLB_ENTRIES-1:0] match;
    logic                    do_write;

    assign lu_vpn = lu_vaddr_i[PAGE_OFS +: VPNW];

    // flush takes priority over a refill in the same cycle
    assign do_write = upd_valid_i && !flush_i;

    // ------------------------------------------------------------
    // lookup
    // ------------------------------------------------------------

    // level 2 always compared
    // level 1 skipped for 1G pages, level 0 only compared for 4K
    always_comb begin
        for (int i = 0; i < DTLB_ENTRIES; i++) begin
            match[i] = valid_q[i]
                && (tag_q[i][2*LVLW +: LVLW] == lu_vpn[2*LVLW +: LVLW])
                && ((size_q[i] == PAGE_1G)
                    || (tag_q[i][LVLW +: LVLW] == lu_vpn[LVLW +: LVLW]))
                && ((size_q[i] != PAGE_4K)
                    || (tag_q[i][0 +: LVLW] == lu_vpn[0 +: LVLW]));
        end
    end

    // walk from the top down so the lowest matching index wins
    always_comb begin
        lu_hit_o   = 1'b0;
        lu_ppn_o   = '0;
        lu_flags_o = '0;
        lu_size_o  = PAGE_4K;
        for (int i = DTLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                lu_hit_o   = 1'b1;
                // raw entry ppn, superpage merge happens downstream
                lu_ppn_o   = ppn_q[i];
                lu_flags_o = flags_q[i];
                lu_size_o  = size_q[i];
            end
        end
    end

    // ------------------------------------------------------------
    // refill and flush
    // ------------------------------------------------------------

    // valid bits and pointer
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            ptr_q   <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
            ptr_q   <= '0;
        end else if (upd_valid_i) begin
            valid_q[ptr_q] <= 1'b1;
            // wrap at the last entry, count need not be a power of two
            if (ptr_q == PTRW'(DTLB_ENTRIES - 1)) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= ptr_q + 1'b1;
            end
        end
    end

    // entry payload, no duplicate check on refill
    always_ff @(posedge clk_i) begin
        if (do_write) begin
            tag_q[ptr_q]   <= upd_vpn_i;
            size_q[ptr_q]  <= upd_size_i;
            ppn_q[ptr_q]   <= upd_ppn_i;
            flags_q[ptr_q] <= upd_flags_i;
        end
    end

endmodule

// File: hw/pte_perm_check.sv
`timescale 1ns/1ps

module pte_perm_check import sv39_pkg::*; import mmu_pkg::*; (
    // flags of the hit entry
    input  logic [NFLAGS-1:0] flags_i,
    input  logic              is_store_i,
    // effective privilege of the load/store
    input  priv_lvl_e         priv_i,
    // supervisor may touch user pages
    input  logic              sum_i,
    // executable pages readable
    input  logic              mxr_i,
    output logic              fault_o
);

    logic priv_err;
    logic not_accessed;
    logic store_err;
    logic load_err;
    logic readable;

    // ------------------------------------------------------------
    // privilege rule
    // ------------------------------------------------------------

    // user mode only on U pages
    // S and M mode on U pages only with SUM set
    // machine mode follows the supervisor rule here
    always_comb begin
        if (priv_i == PRIV_U) begin
            priv_err = !flags_i[FLAG_U];
        end else begin
            priv_err = flags_i[FLAG_U] && !sum_i;
        end
    end

    // ------------------------------------------------------------
    // access type rules
    // ------------------------------------------------------------

    // A is never set by hardware, a clear A always faults
    assign not_accessed = !flags_i[FLAG_A];

    // store needs W, and D since dirty tracking is left to software
    assign store_err = !flags_i[FLAG_W] || !flags_i[FLAG_D];

    // mxr lets an X page be read
    assign readable = flags_i[FLAG_R] || (mxr_i && flags_i[FLAG_X]);
    assign load_err = !readable;

    assign fault_o = not_accessed || priv_err || (is_store_i ? store_err : load_err);

endmodule

// File: hw/ld_st_xlate.sv
`timescale 1ns/1ps

module ld_st_xlate import sv39_pkg::*; import mmu_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    // request seen in the lookup cycle
    input  logic              req_i,
    input  logic [VLEN-1:0]   vaddr_i,
    input  logic              is_store_i,
    input  logic              xlate_en_i,
    // tlb answer of the same cycle
    input  logic              hit_i,
    input  logic [PPNW-1:0]   ppn_i,
    input  logic [NFLAGS-1:0] flags_i,
    input  page_size_e        size_i,
    // status bits, used live
    input  priv_lvl_e         priv_i,
    input  logic              sum_i,
    input  logic              mxr_i,
    // result, one cycle after the request
    output logic              valid_o,
    output logic [PLEN-1:0]   paddr_o,
    output logic              exc_valid_o,
    output exc_cause_e        exc_cause_o,
    output logic [VLEN-1:0]   exc_tval_o
);

    // control state
    logic req_q;
    logic hit_q;
    logic xlate_en_q;

    // payload of the request and the tlb entry
    logic [VLEN-1:0]   vaddr_q;
    logic              is_store_q;
    logic [PPNW-1:0]   ppn_q;
    logic [NFLAGS-1:0] flags_q;
    page_size_e        size_q;

    logic fault;

    // ------------------------------------------------------------
    // stage register
    // ------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q      <= 1'b0;
            hit_q      <= 1'b0;
            xlate_en_q <= 1'b0;
        end else begin
            req_q      <= req_i;
            hit_q      <= hit_i;
            xlate_en_q <= xlate_en_i;
        end
    end

    always_ff @(posedge clk_i) begin
        vaddr_q    <= vaddr_i;
        is_store_q <= is_store_i;
        ppn_q      <= ppn_i;
        flags_q    <= flags_i;
        size_q     <= size_i;
    end

    // ------------------------------------------------------------
    // permission check on the registered entry
    // ------------------------------------------------------------

    pte_perm_check i_perm (
        .flags_i    ( flags_q    ),
        .is_store_i ( is_store_q ),
        .priv_i     ( priv_i     ),
        .sum_i      ( sum_i      ),
        .mxr_i      ( mxr_i      ),
        .fault_o    ( fault      )
    );

    // ------------------------------------------------------------
    // address and exception
    // ------------------------------------------------------------

    // a miss gives nothing, the requester refills and retries
    assign valid_o = req_q && (!xlate_en_q || hit_q);

    always_comb begin
        if (xlate_en_q) begin
            // 4K page
            paddr_o = {ppn_q, vaddr_q[PAGE_OFS-1:0]};
            // 2M page, vpn level 0 passes through
            if (size_q == PAGE_2M) begin
                paddr_o[20:12] = vaddr_q[20:12];
            end
            // 1G page, vpn levels 1 and 0 pass through
            if (size_q == PAGE_1G) begin
                paddr_o[29:12] = vaddr_q[29:12];
            end
        end else begin
            // bypass, zero-extended virtual address
            paddr_o = PLEN'(vaddr_q);
        end
    end

    // bypass never faults
    assign exc_valid_o = valid_o && xlate_en_q && fault;

    always_comb begin
        exc_cause_o = EXC_NONE;
        exc_tval_o  = '0;
        if (exc_valid_o) begin
            exc_cause_o = is_store_q ? EXC_ST_PAGE_FAULT : EXC_LD_PAGE_FAULT;
            exc_tval_o  = vaddr_q;
        end
    end

endmodule

// File: hw/dmmu.sv
`timescale 1ns/1ps

module dmmu import sv39_pkg::*; import mmu_pkg::*; #(
    parameter int unsigned DTLB_ENTRIES = 4
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              en_ld_st_translation_i,
    // load/store request
    input  logic              lsu_req_i,
    input  logic [VLEN-1:0]   lsu_vaddr_i,
    input  logic              lsu_is_store_i,
    input  priv_lvl_e         ld_st_priv_lvl_i,
    input  logic              sum_i,
    input  logic              mxr_i,
    // tlb maintenance
    input  logic              flush_tlb_i,
    input  logic              upd_valid_i,
    input  logic [VPNW-1:0]   upd_vpn_i,
    input  page_size_e        upd_size_i,
    input  logic [PPNW-1:0]   upd_ppn_i,
    input  logic [NFLAGS-1:0] upd_flags_i,
    // cycle 0
    output logic              dtlb_hit_o,
    output logic [PPNW-1:0]   dtlb_ppn_o,
    output logic              dtlb_miss_o,
    // cycle 1
    output logic              lsu_valid_o,
    output logic [PLEN-1:0]   lsu_paddr_o,
    output logic              lsu_exc_valid_o,
    output exc_cause_e        lsu_exc_cause_o,
    output logic [VLEN-1:0]   lsu_exc_tval_o
);

    logic              lookup_req;
    logic [VLEN-1:0]   lookup_vaddr;
    logic              lookup_is_store;

    logic              tlb_hit;
    logic [PPNW-1:0]   tlb_ppn;
    logic [NFLAGS-1:0] tlb_flags;
    page_size_e        tlb_size;

    assign lookup_req      = lsu_req_i;
    assign lookup_vaddr    = lsu_vaddr_i;
    assign lookup_is_store = lsu_is_store_i;

    dtlb #(
        .DTLB_ENTRIES ( DTLB_ENTRIES )
    ) i_dtlb (
        .clk_i       ( clk_i        ),
        .rst_ni      ( rst_ni       ),
        .flush_i     ( flush_tlb_i  ),
        .upd_valid_i ( upd_valid_i  ),
        .upd_vpn_i   ( upd_vpn_i    ),
        .upd_size_i  ( upd_size_i   ),
        .upd_ppn_i   ( upd_ppn_i    ),
        .upd_flags_i ( upd_flags_i  ),
        .lu_vaddr_i  ( lookup_vaddr ),
        .lu_hit_o    ( tlb_hit      ),
        .lu_ppn_o    ( tlb_ppn      ),
        .lu_flags_o  ( tlb_flags    ),
        .lu_size_o   ( tlb_size     )
    );

    // ------------------------------------------------------------
    // cycle 0 outputs
    // ------------------------------------------------------------

    // bypass always counts as a hit
    assign dtlb_hit_o  = en_ld_st_translation_i ? tlb_hit : 1'b1;
    // miss strobe, the only counter event kept
    assign dtlb_miss_o = lookup_req && en_ld_st_translation_i && !tlb_hit;

    always_comb begin
        if (en_ld_st_translation_i) begin
            dtlb_ppn_o = tlb_ppn;
            // superpages take the lower vpn levels from the request
            if (tlb_size == PAGE_2M) begin
                dtlb_ppn_o[8:0] = lookup_vaddr[20:12];
            end
            if (tlb_size == PAGE_1G) begin
                dtlb_ppn_o[17:0] = lookup_vaddr[29:12];
            end
        end else begin
            dtlb_ppn_o = PPNW'(lookup_vaddr[VLEN-1:PAGE_OFS]);
        end
    end

    // ------------------------------------------------------------
    // cycle 1 stage
    // ------------------------------------------------------------

    ld_st_xlate i_xlate (
        .clk_i       ( clk_i                  ),
        .rst_ni      ( rst_ni                 ),
        .req_i       ( lookup_req             ),
        .vaddr_i     ( lookup_vaddr           ),
        .is_store_i  ( lookup_is_store        ),
        .xlate_en_i  ( en_ld_st_translation_i ),
        .hit_i       ( tlb_hit                ),
        .ppn_i       ( tlb_ppn                ),
        .flags_i     ( tlb_flags              ),
        .size_i      ( tlb_size               ),
        .priv_i      ( ld_st_priv_lvl_i       ),
        .sum_i       ( sum_i                  ),
        .mxr_i       ( mxr_i                  ),
        .valid_o     ( lsu_valid_o            ),
        .paddr_o     ( lsu_paddr_o            ),
        .exc_valid_o ( lsu_exc_valid_o        ),
        .exc_cause_o ( lsu_exc_cause_o        ),
        .exc_tval_o  ( lsu_exc_tval_o         )
    );

endmodule

// File: bench/dmmu_assert.sv
`timescale 1ns/1ps

module dmmu_assert (
    input logic clk_i,
    input logic rst_ni,
    input logic lsu_req_i,
    input logic dtlb_hit_o,
    input logic dtlb_miss_o,
    input logic lsu_valid_o,
    input logic lsu_exc_valid_o
);

    // ------------------------------------------------------------
    // top-level timing rules
    // ------------------------------------------------------------

    // a lookup is either a hit or a miss, never both
    hit_miss_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(dtlb_hit_o && dtlb_miss_o))
        else $error("dtlb_hit_o and dtlb_miss_o high together");

    // an exception only rides on a valid result
    exc_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_exc_valid_o |-> lsu_valid_o)
        else $error("lsu_exc_valid_o without lsu_valid_o");

    // result one cycle after its request
    valid_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_valid_o |-> $past(lsu_req_i))
        else $error("lsu_valid_o without a request in the previous cycle");

endmodule

bind dmmu dmmu_assert i_dmmu_assert (.*);

// File: bench/dmmu_tb.sv
`timescale 1ns/1ps

module dmmu_tb import sv39_pkg::*; import mmu_pkg::*; ();

    localparam int unsigned NUM_ENTRIES = 4;
    localparam int unsigned CLK_PERIOD = 8;
    localparam int unsigned TIMEOUT_CYCLES = 20;
    localparam logic [31:0] RNG_SEED = 32'd75590;

    // single flag bits
    localparam logic [NFLAGS-1:0] F_V = NFLAGS'(1 << FLAG_V);
    localparam logic [NFLAGS-1:0] F_R = NFLAGS'(1 << FLAG_R);
    localparam logic [NFLAGS-1:0] F_W = NFLAGS'(1 << FLAG_W);
    localparam logic [NFLAGS-1:0] F_X = NFLAGS'(1 << FLAG_X);
    localparam logic [NFLAGS-1:0] F_U = NFLAGS'(1 << FLAG_U);
    localparam logic [NFLAGS-1:0] F_A = NFLAGS'(1 << FLAG_A);
    localparam logic [NFLAGS-1:0] F_D = NFLAGS'(1 << FLAG_D);
    // fully usable supervisor data page
    localparam logic [NFLAGS-1:0] F_RWAD = F_V | F_R | F_W | F_A | F_D;

    logic              clk_i;
    logic              rst_ni;
    logic              en_ld_st_translation_i;
    logic              lsu_req_i;
    logic [VLEN-1:0]   lsu_vaddr_i;
    logic              lsu_is_store_i;
    priv_lvl_e         ld_st_priv_lvl_i;
    logic              sum_i;
    logic              mxr_i;
    logic              flush_tlb_i;
    logic              upd_valid_i;
    logic [VPNW-1:0]   upd_vpn_i;
    page_size_e        upd_size_i;
    logic [PPNW-1:0]   upd_ppn_i;
    logic [NFLAGS-1:0] upd_flags_i;
    logic              dtlb_hit_o;
    logic [PPNW-1:0]   dtlb_ppn_o;
    logic              dtlb_miss_o;
    logic              lsu_valid_o;
    logic [PLEN-1:0]   lsu_paddr_o;
    logic              lsu_exc_valid_o;
    exc_cause_e        lsu_exc_cause_o;
    logic [VLEN-1:0]   lsu_exc_tval_o;

    // captured response of the last request
    logic              r_hit0;
    logic              r_miss0;
    logic [PPNW-1:0]   r_ppn0;
    logic              r_valid;
    logic [PLEN-1:0]   r_paddr;
    logic              r_exc;
    exc_cause_e        r_cause;
    logic [VLEN-1:0]   r_tval;

    logic [31:0] rng_state;

    dmmu #(
        .DTLB_ENTRIES ( NUM_ENTRIES )
    ) dmmu_i (
        .*
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic logic [VLEN-1:0] rand_vaddr();
        logic [63:0] r;
        r = {next_rand(), next_rand()};
        return r[VLEN-1:0];
    endfunction

    function automatic logic [PPNW-1:0] rand_ppn();
        logic [63:0] r;
        r = {next_rand(), next_rand()};
        return r[PPNW-1:0];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %0h actual %0h", name, exp, act);
            abort_run("value mismatch");
        end
    endtask

    task automatic set_status(input logic en, input priv_lvl_e priv, input logic sum,
                              input logic mxr);
        @(posedge clk_i);
        en_ld_st_translation_i <= en;
        ld_st_priv_lvl_i       <= priv;
        sum_i                  <= sum;
        mxr_i                  <= mxr;
    endtask

    task automatic do_flush();
        @(posedge clk_i);
        flush_tlb_i <= 1'b1;
        @(posedge clk_i);
        flush_tlb_i <= 1'b0;
    endtask

    // one-cycle pulse on the update port
    task automatic do_refill(input logic [VPNW-1:0] vpn, input page_size_e size,
                             input logic [PPNW-1:0] ppn, input logic [NFLAGS-1:0] flags);
        @(posedge clk_i);
        upd_valid_i <= 1'b1;
        upd_vpn_i   <= vpn;
        upd_size_i  <= size;
        upd_ppn_i   <= ppn;
        upd_flags_i <= flags;
        @(posedge clk_i);
        upd_valid_i <= 1'b0;
    endtask

    // cycle 0 sampled mid-cycle, then wait for the registered result
    task automatic do_request(input logic [VLEN-1:0] va, input logic st, input logic want_valid);
        int unsigned waited;
        @(posedge clk_i);
        lsu_req_i      <= 1'b1;
        lsu_vaddr_i    <= va;
        lsu_is_store_i <= st;
        @(negedge clk_i);
        r_hit0  = dtlb_hit_o;
        r_miss0 = dtlb_miss_o;
        r_ppn0  = dtlb_ppn_o;
        @(posedge clk_i);
        lsu_req_i <= 1'b0;
        r_valid = 1'b0;
        waited  = 0;
        while (!r_valid && waited < TIMEOUT_CYCLES) begin
            @(negedge clk_i);
            if (lsu_valid_o) begin
                r_valid = 1'b1;
                r_paddr = lsu_paddr_o;
                r_exc   = lsu_exc_valid_o;
                r_cause = lsu_exc_cause_o;
                r_tval  = lsu_exc_tval_o;
            end
            waited++;
        end
        if (want_valid && !r_valid) begin
            abort_run("timeout while waiting for lsu_valid_o");
        end
        if (!want_valid && r_valid) begin
            abort_run("lsu_valid_o came for a request that should have missed");
        end
    endtask

    task automatic expect_ok(input string name, input logic [VLEN-1:0] va, input logic st,
                             input logic [PLEN-1:0] exp_paddr);
        do_request(va, st, 1'b1);
        check({name, " hit0"}, 64'd1, 64'(r_hit0));
        check({name, " paddr"}, 64'(exp_paddr), 64'(r_paddr));
        check({name, " exc"}, 64'd0, 64'(r_exc));
    endtask

    task automatic expect_fault(input string name, input logic [VLEN-1:0] va, input logic st,
                                input exc_cause_e cause);
        do_request(va, st, 1'b1);
        check({name, " exc"}, 64'd1, 64'(r_exc));
        check({name, " cause"}, 64'(cause), 64'(r_cause));
        check({name, " tval"}, 64'(va), 64'(r_tval));
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------

    task automatic test_bypass();
        logic [VLEN-1:0] va;
        logic [31:0]     r;
        set_status(1'b0, PRIV_S, 1'b0, 1'b0);
        for (int i = 0; i < 8; i++) begin
            va = rand_vaddr();
            r  = next_rand();
            expect_ok("bypass", va, r[0], PLEN'(va));
            check("bypass ppn0", 64'(PPNW'(va[VLEN-1:PAGE_OFS])), 64'(r_ppn0));
            check("bypass miss0", 64'd0, 64'(r_miss0));
        end
    endtask

    task automatic test_4k();
        logic [VLEN-1:0] va;
        logic [PPNW-1:0] ppn;
        do_flush();
        set_status(1'b1, PRIV_S, 1'b0, 1'b0);
        va  = rand_vaddr();
        ppn = rand_ppn();
        do_refill(va[VLEN-1:PAGE_OFS], PAGE_4K, ppn, F_RWAD);
        expect_ok("4k load", va, 1'b0, {ppn, va[PAGE_OFS-1:0]});
        check("4k ppn0", 64'(ppn), 64'(r_ppn0));
        expect_ok("4k store", va, 1'b1, {ppn, va[PAGE_OFS-1:0]});
    endtask

    // lower tag levels get junk, they must be ignored
    task automatic test_superpage();
        logic [VLEN-1:0] va;
        logic [PPNW-1:0] ppn;
        logic [31:0]     junk;
        do_flush();
        va   = rand_vaddr();
        ppn  = rand_ppn();
        junk = next_rand();
        do_refill({va[38:21], junk[8:0]}, PAGE_2M, ppn, F_RWAD);
        expect_ok("2m load", va, 1'b0, {ppn[43:9], va[20:0]});
        check("2m ppn0", 64'({ppn[43:9], va[20:12]}), 64'(r_ppn0));
        do_flush();
        va   = rand_vaddr();
        ppn  = rand_ppn();
        junk = next_rand();
        do_refill({va[38:30], junk[17:0]}, PAGE_1G, ppn, F_RWAD);
        expect_ok("1g store", va, 1'b1, {ppn[43:18], va[29:0]});
        check("1g ppn0", 64'({ppn[43:18], va[29:12]}), 64'(r_ppn0));
    endtask

    task automatic test_perm_faults();
        logic [VLEN-1:0] va [4];
        logic [PPNW-1:0] ppn [4];
        do_flush();
        for (int i = 0; i < 4; i++) begin
            va[i]  = rand_vaddr();
            ppn[i] = rand_ppn();
        end
        do_refill(va[0][VLEN-1:PAGE_OFS], PAGE_4K, ppn[0], F_V | F_R | F_W | F_A);
        do_refill(va[1][VLEN-1:PAGE_OFS], PAGE_4K, ppn[1], F_RWAD);
        do_refill(va[2][VLEN-1:PAGE_OFS], PAGE_4K, ppn[2], F_RWAD | F_U);
        do_refill(va[3][VLEN-1:PAGE_OFS], PAGE_4K, ppn[3], F_V | F_X | F_A);
        set_status(1'b1, PRIV_S, 1'b0, 1'b0);
        expect_fault("store no dirty", va[0], 1'b1, EXC_ST_PAGE_FAULT);
        set_status(1'b1, PRIV_U, 1'b0, 1'b0);
        expect_fault("user on s page", va[1], 1'b0, EXC_LD_PAGE_FAULT);
        set_status(1'b1, PRIV_S, 1'b0, 1'b0);
        expect_fault("s on u page", va[2], 1'b0, EXC_LD_PAGE_FAULT);
        expect_fault("x only mxr off", va[3], 1'b0, EXC_LD_PAGE_FAULT);
        set_status(1'b1, PRIV_S, 1'b1, 1'b0);
        expect_ok("s on u page sum", va[2], 1'b0, {ppn[2], va[2][PAGE_OFS-1:0]});
        set_status(1'b1, PRIV_S, 1'b0, 1'b1);
        expect_ok("x only mxr on", va[3], 1'b0, {ppn[3], va[3][PAGE_OFS-1:0]});
        set_status(1'b1, PRIV_S, 1'b0, 1'b0);
    endtask

    task automatic test_miss_flush();
        logic [VLEN-1:0] va;
        logic [PPNW-1:0] ppn;
        do_flush();
        va  = rand_vaddr();
        ppn = rand_ppn();
        do_request(va, 1'b0, 1'b0);
        check("miss miss0", 64'd1, 64'(r_miss0));
        check("miss hit0", 64'd0, 64'(r_hit0));
        do_refill(va[VLEN-1:PAGE_OFS], PAGE_4K, ppn, F_RWAD);
        expect_ok("refilled", va, 1'b0, {ppn, va[PAGE_OFS-1:0]});
        check("refilled miss0", 64'd0, 64'(r_miss0));
        do_flush();
        do_request(va, 1'b0, 1'b0);
        check("flushed miss0", 64'd1, 64'(r_miss0));
    endtask

    // one refill more than entries, the oldest entry goes
    task automatic test_round_robin();
        logic [VLEN-1:0] va [NUM_ENTRIES+1];
        logic [PPNW-1:0] ppn [NUM_ENTRIES+1];
        logic            dup;
        do_flush();
        for (int i = 0; i <= NUM_ENTRIES; i++) begin
            dup = 1'b1;
            while (dup) begin
                va[i] = rand_vaddr();
                dup   = 1'b0;
                for (int j = 0; j < i; j++) begin
                    if (va[j][VLEN-1:PAGE_OFS] == va[i][VLEN-1:PAGE_OFS]) begin
                        dup = 1'b1;
                    end
                end
            end
            ppn[i] = rand_ppn();
            do_refill(va[i][VLEN-1:PAGE_OFS], PAGE_4K, ppn[i], F_RWAD);
        end
        do_request(va[0], 1'b0, 1'b0);
        check("evicted miss0", 64'd1, 64'(r_miss0));
        for (int i = 1; i <= NUM_ENTRIES; i++) begin
            expect_ok("kept", va[i], 1'b0, {ppn[i], va[i][PAGE_OFS-1:0]});
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------

    initial begin
        rng_state              = RNG_SEED;
        rst_ni                 = 1'b0;
        en_ld_st_translation_i = 1'b0;
        // request held during reset, the stage register must stay empty
        lsu_req_i              = 1'b1;
        lsu_vaddr_i            = '0;
        lsu_is_store_i         = 1'b0;
        ld_st_priv_lvl_i       = PRIV_S;
        sum_i                  = 1'b0;
        mxr_i                  = 1'b0;
        flush_tlb_i            = 1'b0;
        upd_valid_i            = 1'b0;
        upd_vpn_i              = '0;
        upd_size_i             = PAGE_4K;
        upd_ppn_i              = '0;
        upd_flags_i            = '0;
        repeat (3) @(posedge clk_i);
        rst_ni    <= 1'b1;
        lsu_req_i <= 1'b0;
        @(negedge clk_i);
        check("reset valid", 64'd0, 64'(lsu_valid_o));
        check("reset exc", 64'd0, 64'(lsu_exc_valid_o));
        test_bypass();
        test_4k();
        test_superpage();
        test_perm_faults();
        test_miss_flush();
        test_round_robin();
        $display("Regression passed");
        $finish;
    end

endmodule

// File: sources.f
hw/sv39_pkg.sv
hw/mmu_pkg.sv
hw/dtlb.sv
hw/pte_perm_check.sv
hw/ld_st_xlate.sv
hw/dmmu.sv
bench/dmmu_assert.sv
bench/dmmu_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module dmmu_tb -f sources.f -o dmmu_sim

# the simulator status is not trusted, the log decides
./obj_dir/dmmu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression passed" sim.log; then
    exit 0
fi
exit 1
